/* hw/trace_pkg.sv */
// trace sniffer shared definitions
// sizes, register map, APB transfer structs, match rule config
// and the capture FIFO word with its match/data record views
`default_nettype none

package trace_pkg;

   localparam int nibble_w    = 4;
   localparam int buf_nibbles = 8;
   localparam int buf_w       = nibble_w * buf_nibbles;
   localparam int num_rules   = 4;
   localparam int rule_idx_w  = 2;
   localparam int fifo_depth  = 32;
   localparam int fifo_addr_w = 5;
   localparam int time_w      = 11;
   localparam int wait_w      = 13;
   localparam int cnt_w       = 16;
   localparam int apb_addr_w  = 8;
   localparam int apb_data_w  = 32;

   // register offsets, byte addressed
   localparam logic [apb_addr_w-1:0] reg_ctrl         = 8'h00;
   localparam logic [apb_addr_w-1:0] reg_status       = 8'h04;  // read only
   localparam logic [apb_addr_w-1:0] reg_pattern_base = 8'h10;  // stride 8 per rule
   localparam logic [apb_addr_w-1:0] reg_mask_base    = 8'h14;
   localparam logic [apb_addr_w-1:0] reg_capture_len  = 8'h30;
   localparam logic [apb_addr_w-1:0] reg_trig_delay   = 8'h34;
   localparam logic [apb_addr_w-1:0] reg_trig_width   = 8'h38;
   localparam logic [apb_addr_w-1:0] reg_fifo_data    = 8'h3C;  // read pops

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [apb_addr_w-1:0] paddr;
      logic [apb_data_w-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [apb_data_w-1:0] prdata;
      logic                  pready;
      logic                  pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic [buf_w-1:0] pattern;
      logic [buf_w-1:0] mask;     // 1 = bit must match
      logic             enable;
   } rule_cfg_t;

   // kind bit on top in both views
   typedef struct packed {
      logic                  kind;         // 1
      logic [rule_idx_w-1:0] rule;
      logic [wait_w-1:0]     wait_cycles;  // arm to match, saturating
   } match_rec_t;

   typedef struct packed {
      logic                kind;    // 0
      logic [nibble_w-1:0] nibble;
      logic [time_w-1:0]   stamp;   // cycles since match, wraps
   } data_rec_t;

   typedef union packed {
      match_rec_t match;
      data_rec_t  data;
   } capture_entry_u;

endpackage

`default_nettype wire

/* hw/trace_ctrl.sv */
// trace sniffer control block
// APB register file, idle/armed/capture FSM and the record builder
// that feeds the capture FIFO
`timescale 1ns/1ps
`default_nettype none

module trace_ctrl
   import trace_pkg::*;
(
   input  logic                      trace_clk,
   input  logic                      reset,
   input  apb_req_t                  apb_req,
   output apb_rsp_t                  apb_rsp,
   input  logic [nibble_w-1:0]       trace_data,
   input  logic                      trace_valid,
   input  logic                      hit,
   input  logic [rule_idx_w-1:0]     hit_rule,
   output rule_cfg_t [num_rules-1:0] rules,
   output logic                      buf_clear,
   output logic                      trig_start,
   output logic [cnt_w-1:0]          trig_delay,
   output logic [cnt_w-1:0]          trig_width,
   output logic                      push,
   output capture_entry_u            push_entry,
   output logic                      pop,
   input  capture_entry_u            pop_entry,
   input  logic                      full,
   input  logic                      empty,
   input  logic [fifo_addr_w:0]      count,
   output logic                      armed,
   output logic                      capturing
);

   typedef enum logic [1:0] {st_idle, st_armed, st_capture} state_t;

   state_t                state;
   logic [cnt_w-1:0]      capture_len;
   logic [cnt_w-1:0]      left_cnt;     // data records still to take
   logic [wait_w-1:0]     wait_cnt;
   logic [time_w-1:0]     time_cnt;
   logic                  overflow;
   logic                  access;
   logic                  mapped;
   logic                  wr_en;
   logic                  rd_en;
   logic                  arm_wr;
   logic                  is_rule;
   logic                  is_mask;
   logic                  take_match;
   logic [apb_addr_w-1:0] rule_off;
   logic [rule_idx_w-1:0] rule_sel;

   // pattern/mask window decode
   assign rule_off = apb_req.paddr - reg_pattern_base;
   assign rule_sel = rule_off[3 +: rule_idx_w];
   assign is_mask  = rule_off[2];
   assign is_rule  = (apb_req.paddr >= reg_pattern_base) && (apb_req.paddr < reg_capture_len)
                     && (apb_req.paddr[1:0] == 2'b00);
   assign mapped   = is_rule || (apb_req.paddr inside {reg_ctrl, reg_status, reg_capture_len,
                                                       reg_trig_delay, reg_trig_width,
                                                       reg_fifo_data});

   assign access = apb_req.psel & apb_req.penable;
   assign wr_en  = access & apb_req.pwrite & mapped;
   assign rd_en  = access & ~apb_req.pwrite & mapped;
   assign arm_wr = wr_en && (apb_req.paddr == reg_ctrl) && apb_req.pwdata[0];
   assign pop    = rd_en && (apb_req.paddr == reg_fifo_data) && !empty;

   assign armed      = (state == st_armed);
   assign capturing  = (state == st_capture);
   assign take_match = armed && hit;
   assign trig_start = take_match;
   assign buf_clear  = arm_wr;     // fresh eight nibbles needed after arming
   assign push       = take_match || (capturing && trace_valid);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         rules       <= '0;
         capture_len <= '0;
         trig_delay  <= '0;
         trig_width  <= '0;
      end else if (wr_en) begin
         if (is_rule) begin
            if (is_mask)
               rules[rule_sel].mask <= apb_req.pwdata;
            else
               rules[rule_sel].pattern <= apb_req.pwdata;
         end
         case (apb_req.paddr)
            reg_ctrl: begin
               for (int i = 0; i < num_rules; i++)
                  rules[i].enable <= apb_req.pwdata[4+i];
            end
            reg_capture_len: capture_len <= apb_req.pwdata[cnt_w-1:0];
            reg_trig_delay:  trig_delay  <= apb_req.pwdata[cnt_w-1:0];
            reg_trig_width:  trig_width  <= apb_req.pwdata[cnt_w-1:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state    <= st_idle;
         overflow <= 1'b0;
         wait_cnt <= '0;
         time_cnt <= '0;
         left_cnt <= '0;
      end else begin
         if (push && full)
            overflow <= 1'b1;                      // dropped record
         if (arm_wr) begin
            state    <= st_armed;
            overflow <= 1'b0;
            wait_cnt <= '0;
         end else begin
            case (state)
               st_armed: begin
                  if (hit) begin
                     time_cnt <= time_w'(1);
                     left_cnt <= capture_len;
                     state    <= (capture_len == '0) ? st_idle : st_capture;
                  end else if (wait_cnt != '1) begin
                     wait_cnt <= wait_cnt + 1'b1;  // saturates
                  end
               end
               st_capture: begin
                  time_cnt <= time_cnt + 1'b1;
                  if (trace_valid) begin
                     left_cnt <= left_cnt - 1'b1;
                     if (left_cnt == cnt_w'(1))
                        state <= st_idle;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // record builder, match view in the match cycle, data view afterwards
   always_comb begin
      push_entry = '0;
      if (capturing) begin
         push_entry.data.kind   = 1'b0;
         push_entry.data.nibble = trace_data;
         push_entry.data.stamp  = time_cnt;
      end else begin
         push_entry.match.kind        = 1'b1;
         push_entry.match.rule        = hit_rule;
         push_entry.match.wait_cycles = wait_cnt;
      end
   end

   always_comb begin
      apb_rsp.pready  = 1'b1;                      // zero wait states
      apb_rsp.pslverr = access & ~mapped;
      apb_rsp.prdata  = '0;
      if (rd_en) begin
         if (is_rule)
            apb_rsp.prdata = is_mask ? rules[rule_sel].mask : rules[rule_sel].pattern;
         case (apb_req.paddr)
            reg_ctrl: begin
               apb_rsp.prdata[0] = armed;
               for (int i = 0; i < num_rules; i++)
                  apb_rsp.prdata[4+i] = rules[i].enable;
            end
            reg_status: begin
               apb_rsp.prdata[3:0]               = {overflow, empty, capturing, armed};
               apb_rsp.prdata[8 +: fifo_addr_w+1] = count;
            end
            reg_capture_len: apb_rsp.prdata[cnt_w-1:0] = capture_len;
            reg_trig_delay:  apb_rsp.prdata[cnt_w-1:0] = trig_delay;
            reg_trig_width:  apb_rsp.prdata[cnt_w-1:0] = trig_width;
            reg_fifo_data: begin
               if (!empty)
                  apb_rsp.prdata[$bits(capture_entry_u)-1:0] = pop_entry;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/trace_matcher.sv */
// trace pattern matcher
// keeps the last eight trace nibbles and checks them against four
// masked patterns, lowest enabled rule wins
`timescale 1ns/1ps
`default_nettype none

module trace_matcher
   import trace_pkg::*;
(
   input  logic                      trace_clk,
   input  logic                      reset,
   input  logic [nibble_w-1:0]       trace_data,
   input  logic                      trace_valid,
   input  logic                      buf_clear,
   input  rule_cfg_t [num_rules-1:0] rules,
   output logic                      hit,
   output logic [rule_idx_w-1:0]     hit_rule
);

   logic [buf_w-1:0]              shift_buf;
   logic [$clog2(buf_nibbles):0]  fill;        // nibbles since last clear
   logic                          buf_full;
   logic [num_rules-1:0]          rule_hit;
   logic [rule_idx_w-1:0]         first_rule;

   assign buf_full = (fill == $bits(fill)'(buf_nibbles));

   // newest nibble enters at the bottom
   always_ff @(posedge trace_clk) begin
      if (trace_valid)
         shift_buf <= {shift_buf[buf_w-nibble_w-1:0], trace_data};
   end

   always_comb begin
      for (int i = 0; i < num_rules; i++)
         rule_hit[i] = rules[i].enable
                       && (((shift_buf ^ rules[i].pattern) & rules[i].mask) == '0);
   end

   // walk down so the lowest index is left standing
   always_comb begin
      first_rule = '0;
      for (int i = num_rules - 1; i >= 0; i--) begin
         if (rule_hit[i])
            first_rule = rule_idx_w'(i);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset || buf_clear) begin
         fill     <= '0;
         hit      <= 1'b0;
         hit_rule <= '0;
      end else begin
         if (trace_valid && !buf_full)
            fill <= fill + 1'b1;
         hit      <= buf_full && (|rule_hit);  // registered, one cycle behind buffer
         hit_rule <= first_rule;
      end
   end

endmodule

`default_nettype wire

/* hw/trigger_pulse.sv */
// trigger pulse shaper
// waits trig_delay cycles after a start, then drives trig_out high
// for trig_width cycles; starts during a running pulse are dropped
`timescale 1ns/1ps
`default_nettype none

module trigger_pulse
   import trace_pkg::*;
(
   input  logic             trace_clk,
   input  logic             reset,
   input  logic             trig_start,
   input  logic [cnt_w-1:0] trig_delay,
   input  logic [cnt_w-1:0] trig_width,
   output logic             trig_out
);

   logic             delaying;
   logic [cnt_w-1:0] cnt;      // shared by delay and width phase

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         delaying <= 1'b0;
         trig_out <= 1'b0;
         cnt      <= '0;
      end else if (trig_out) begin
         // width phase
         if (cnt == cnt_w'(1))
            trig_out <= 1'b0;
         cnt <= cnt - 1'b1;
      end else if (delaying) begin
         if (cnt == cnt_w'(1)) begin
            delaying <= 1'b0;
            trig_out <= (trig_width != '0);
            cnt      <= trig_width;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end else if (trig_start) begin
         if (trig_delay == '0) begin
            trig_out <= (trig_width != '0);   // zero width never fires
            cnt      <= trig_width;
         end else begin
            delaying <= 1'b1;
            cnt      <= trig_delay;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/capture_fifo.sv */
// capture FIFO
// circular buffer of capture entries, head is presented combinationally,
// pushes while full are dropped
`timescale 1ns/1ps
`default_nettype none

module capture_fifo
   import trace_pkg::*;
(
   input  logic                 trace_clk,
   input  logic                 reset,
   input  logic                 push,
   input  capture_entry_u       push_entry,
   input  logic                 pop,
   output capture_entry_u       pop_entry,
   output logic                 full,
   output logic                 empty,
   output logic [fifo_addr_w:0] count
);

   capture_entry_u         mem [fifo_depth];
   logic [fifo_addr_w-1:0] wr_ptr;
   logic [fifo_addr_w-1:0] rd_ptr;
   logic                   do_push;
   logic                   do_pop;

   assign full      = (count == (fifo_addr_w+1)'(fifo_depth));
   assign empty     = (count == '0);
   assign do_push   = push && !full;
   assign do_pop    = pop && !empty;
   assign pop_entry = mem[rd_ptr];

   always_ff @(posedge trace_clk) begin
      if (do_push)
         mem[wr_ptr] <= push_entry;
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                 // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/trace_top.sv */
// trace sniffer top level
// control block with matcher, trigger shaper and capture FIFO
`timescale 1ns/1ps
`default_nettype none

module trace_top
   import trace_pkg::*;
(
   input  logic                trace_clk,
   input  logic                reset,
   input  logic [nibble_w-1:0] trace_data,
   input  logic                trace_valid,
   input  apb_req_t            apb_req,
   output apb_rsp_t            apb_rsp,
   output logic                trig_out,
   output logic                armed,
   output logic                capturing
);

   rule_cfg_t [num_rules-1:0] rules;
   logic                      buf_clear;
   logic                      hit;
   logic [rule_idx_w-1:0]     hit_rule;
   logic                      trig_start;
   logic [cnt_w-1:0]          trig_delay;
   logic [cnt_w-1:0]          trig_width;
   logic                      push;
   logic                      pop;
   capture_entry_u            push_entry;
   capture_entry_u            pop_entry;
   logic                      full;
   logic                      empty;
   logic [fifo_addr_w:0]      count;

   trace_ctrl u_ctrl (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .trace_data  (trace_data),
      .trace_valid (trace_valid),
      .hit         (hit),
      .hit_rule    (hit_rule),
      .rules       (rules),
      .buf_clear   (buf_clear),
      .trig_start  (trig_start),
      .trig_delay  (trig_delay),
      .trig_width  (trig_width),
      .push        (push),
      .push_entry  (push_entry),
      .pop         (pop),
      .pop_entry   (pop_entry),
      .full        (full),
      .empty       (empty),
      .count       (count),
      .armed       (armed),
      .capturing   (capturing)
   );

   trace_matcher u_matcher (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .trace_valid (trace_valid),
      .buf_clear   (buf_clear),
      .rules       (rules),
      .hit         (hit),
      .hit_rule    (hit_rule)
   );

   trigger_pulse u_trigger (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trig_start  (trig_start),
      .trig_delay  (trig_delay),
      .trig_width  (trig_width),
      .trig_out    (trig_out)
   );

   capture_fifo u_fifo (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .push        (push),
      .push_entry  (push_entry),
      .pop         (pop),
      .pop_entry   (pop_entry),
      .full        (full),
      .empty       (empty),
      .count       (count)
   );

endmodule

`default_nettype wire

/* tests/trace_assertions.sv */
// trace sniffer protocol checks
// bound into the top level to watch the APB response, FIFO occupancy,
// the trigger output and the capture FSM entry
`timescale 1ns/1ps
`default_nettype none

module trace_assertions
   import trace_pkg::*;
(
   input logic             trace_clk,
   input logic             reset,
   input apb_rsp_t         apb_rsp,
   input logic             push,
   input logic             empty,
   input logic [cnt_w-1:0] trig_width,
   input logic             trig_out,
   input logic             armed,
   input logic             capturing
);

   int fail_cnt = 0;   // failures seen so far

   pready_high: assert property (@(posedge trace_clk) disable iff (reset) apb_rsp.pready)
      else begin
         $error("pready low, zero wait state slave stalled");
         fail_cnt++;
      end

   // an empty FIFO only fills through a push
   no_pop_empty: assert property (@(posedge trace_clk) disable iff (reset)
                                  (empty && !push) |=> empty)
      else begin
         $error("FIFO popped while empty");
         fail_cnt++;
      end

   // zero width never fires
   quiet_zero_width: assert property (@(posedge trace_clk) disable iff (reset)
                                      (trig_width == '0) |-> !trig_out)
      else begin
         $error("trig_out high with width register 0");
         fail_cnt++;
      end

   capture_from_armed: assert property (@(posedge trace_clk) disable iff (reset)
                                        $rose(capturing) |-> $past(armed))
      else begin
         $error("capture entered without being armed");
         fail_cnt++;
      end

endmodule

`default_nettype wire

/* tests/trace_tb.sv */
// trace sniffer testbench
// register access over APB, pattern match and capture, rule priority,
// masking, trigger pulse timing and capture FIFO overflow
`timescale 1ns/1ps
`default_nettype none

module trace_tb;
   import trace_pkg::*;

   logic                  trace_clk;
   logic                  reset;
   logic [nibble_w-1:0]   trace_data;
   logic                  trace_valid;
   apb_req_t              apb_req;
   apb_rsp_t              apb_rsp;
   logic                  trig_out;
   logic                  armed;
   logic                  capturing;
   integer                seed;
   logic [apb_data_w-1:0] rdata;      // last APB read data
   logic                  rerr;       // last APB pslverr
   logic [apb_data_w-1:0] pat;
   logic [apb_data_w-1:0] v;
   logic [nibble_w-1:0]   sent [$];
   logic [time_w-1:0]     prev_time;
   int                    t;
   int                    w;
   logic [apb_addr_w-1:0] cnt_regs [3] = '{reg_capture_len, reg_trig_delay, reg_trig_width};

   trace_top uut (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .trace_valid (trace_valid),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .trig_out    (trig_out),
      .armed       (armed),
      .capturing   (capturing)
   );

   bind trace_top trace_assertions u_assertions (.trace_clk(trace_clk), .reset(reset),
      .apb_rsp(apb_rsp), .push(push), .empty(empty), .trig_width(trig_width),
      .trig_out(trig_out), .armed(armed), .capturing(capturing));

   initial begin
      trace_clk = 1'b0;
      forever #4 trace_clk = ~trace_clk;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
   endtask

   always @(negedge trace_clk) begin
      if (uut.u_assertions.fail_cnt != 0)
         abort_run("protocol assertion failed");
   end

   task automatic apply_reset();
      @(posedge trace_clk);
      reset <= 1'b1;
      repeat (10) @(posedge trace_clk);
      reset <= 1'b0;
   endtask

   // one setup and one access cycle with the response sampled mid access
   task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] addr,
                           input logic [apb_data_w-1:0] wdata);
      apb_req_t req;
      req        = '0;
      req.psel   = 1'b1;
      req.pwrite = wr;
      req.paddr  = addr;
      req.pwdata = wdata;
      @(posedge trace_clk);
      apb_req <= req;
      req.penable = 1'b1;
      @(posedge trace_clk);
      apb_req <= req;
      @(negedge trace_clk);
      rdata = apb_rsp.prdata;
      rerr  = apb_rsp.pslverr;
      @(posedge trace_clk);
      apb_req <= '0;
   endtask

   task automatic send_nibble(input logic [nibble_w-1:0] n);
      @(posedge trace_clk);
      trace_data  <= n;
      trace_valid <= 1'b1;
   endtask

   task automatic stop_trace();
      @(posedge trace_clk);
      trace_valid <= 1'b0;
   endtask

   // oldest nibble first so the word lines up with the buffer
   task automatic send_word(input logic [buf_w-1:0] word);
      for (int i = buf_nibbles - 1; i >= 0; i--)
         send_nibble(word[nibble_w*i +: nibble_w]);
   endtask

   task automatic wait_capture();
      int n;
      n = 0;
      do begin
         @(negedge trace_clk);
         n++;
         if (n > 50)
            abort_run("timeout waiting for capture to start");
      end while (!capturing);
   endtask

   task automatic wait_match();
      int n;
      n = 0;
      do begin
         @(negedge trace_clk);
         n++;
         if (n > 50)
            abort_run("timeout waiting for the match to be taken");
      end while (armed);
   endtask

   // rule setup with full mask and then arm with the given enables
   task automatic setup_rule(input int r, input logic [buf_w-1:0] p, input logic [3:0] en);
      apb_xfer(1'b1, 8'(reg_pattern_base + 8*r), p);
      apb_xfer(1'b1, 8'(reg_mask_base + 8*r), '1);
      apb_xfer(1'b1, reg_ctrl, {24'h0, en, 4'h1});
   endtask

   initial begin
      reset       = 1'b1;
      trace_data  = '0;
      trace_valid = 1'b0;
      apb_req     = '0;
      seed        = 32'h8354_55e0;
      apply_reset();
      apb_xfer(1'b0, reg_status, '0);
      check_value("reset status", 32'h4, rdata);
      check_value("reset outputs", 0, {armed, capturing, trig_out});

      // register readback and unmapped access
      for (int i = 0; i < num_rules; i++) begin
         v = $random(seed);
         apb_xfer(1'b1, 8'(reg_pattern_base + 8*i), v);
         check_value("mapped pslverr", 0, rerr);
         apb_xfer(1'b0, 8'(reg_pattern_base + 8*i), '0);
         check_value("pattern readback", v, rdata);
         v = $random(seed);
         apb_xfer(1'b1, 8'(reg_mask_base + 8*i), v);
         apb_xfer(1'b0, 8'(reg_mask_base + 8*i), '0);
         check_value("mask readback", v, rdata);
      end
      foreach (cnt_regs[i]) begin
         v = $random(seed);
         apb_xfer(1'b1, cnt_regs[i], v);
         apb_xfer(1'b0, cnt_regs[i], '0);
         check_value("counter register readback", {16'h0, v[15:0]}, rdata);
      end
      apb_xfer(1'b1, 8'h40, v);
      check_value("unmapped write pslverr", 1, rerr);
      apb_xfer(1'b0, 8'h40, '0);
      check_value("unmapped read pslverr", 1, rerr);

      // match on rule 2 and capture six data records
      apply_reset();
      pat = $random(seed);
      apb_xfer(1'b1, reg_capture_len, 6);
      setup_rule(2, pat, 4'b0100);
      repeat (3) send_nibble(4'($random(seed)));
      send_word(pat);
      stop_trace();
      wait_capture();
      sent.delete();
      repeat (6) begin
         sent.push_back(4'($random(seed)));
         send_nibble(sent[$]);
      end
      stop_trace();
      apb_xfer(1'b0, reg_status, '0);
      check_value("capture status", 32'h0000_0700, rdata);
      apb_xfer(1'b0, reg_fifo_data, '0);
      check_value("match record kind and rule", 3'b110, rdata[15:13]);
      prev_time = '0;
      foreach (sent[i]) begin
         apb_xfer(1'b0, reg_fifo_data, '0);
         check_value("data record nibble", {1'b0, sent[i]}, rdata[15:11]);
         if (rdata[10:0] <= prev_time)
            abort_run("data record time fields do not increase");
         prev_time = rdata[10:0];
      end

      // rules 1 and 3 identical so the lower index has to win
      apply_reset();
      pat = $random(seed);
      apb_xfer(1'b1, 8'(reg_pattern_base + 8), pat);
      apb_xfer(1'b1, 8'(reg_mask_base + 8), '1);
      setup_rule(3, pat, 4'b1010);
      send_word(pat);
      stop_trace();
      wait_match();
      apb_xfer(1'b0, reg_fifo_data, '0);
      check_value("priority rule", 3'b101, rdata[15:13]);

      // masked bits ignored but an unmasked difference blocks the match
      apply_reset();
      pat = $random(seed);
      setup_rule(0, pat, 4'b0001);
      apb_xfer(1'b1, reg_mask_base, 32'hFFFF_FF0F);
      apb_xfer(1'b1, reg_ctrl, 32'h11);          // re-arm after mask change
      send_word(pat ^ 32'h0000_00A0);
      stop_trace();
      wait_match();
      apb_xfer(1'b0, reg_fifo_data, '0);
      check_value("masked match rule", 3'b100, rdata[15:13]);
      apb_xfer(1'b1, reg_ctrl, 32'h11);
      send_word(pat ^ 32'h0000_0100);
      stop_trace();
      repeat (4) @(posedge trace_clk);
      apb_xfer(1'b0, reg_status, '0);
      check_value("unmasked miss status", 32'h5, rdata);

      // trigger pulse with delay 3 and width 5
      apply_reset();
      pat = $random(seed);
      apb_xfer(1'b1, reg_trig_delay, 3);
      apb_xfer(1'b1, reg_trig_width, 5);
      setup_rule(0, pat, 4'b0001);
      send_word(pat);
      stop_trace();
      wait_match();
      t = 1;                                     // cycles since the match cycle
      while (!trig_out) begin
         @(negedge trace_clk);
         t++;
         if (t > 100)
            abort_run("timeout waiting for trig_out to rise");
      end
      check_value("trigger delay", 4, t);
      w = 0;
      while (trig_out) begin
         @(negedge trace_clk);
         w++;
         if (w > 100)
            abort_run("timeout waiting for trig_out to fall");
      end
      check_value("trigger width", 5, w);
      apb_xfer(1'b1, reg_trig_width, 0);
      apb_xfer(1'b1, reg_ctrl, 32'h11);
      send_word(pat);
      stop_trace();
      wait_match();
      repeat (20) begin
         @(negedge trace_clk);
         check_value("zero width trigger", 0, trig_out);
      end

      // capture longer than the FIFO
      apply_reset();
      pat = $random(seed);
      apb_xfer(1'b1, reg_capture_len, 40);
      setup_rule(0, pat, 4'b0001);
      send_word(pat);
      stop_trace();
      wait_capture();
      repeat (40) send_nibble(4'($random(seed)));
      stop_trace();
      apb_xfer(1'b0, reg_status, '0);
      check_value("overflow status", 32'h0000_2008, rdata);
      for (int i = 0; i < fifo_depth; i++) begin
         apb_xfer(1'b0, reg_status, '0);
         check_value("fifo empty before drained", 0, rdata[2]);
         apb_xfer(1'b0, reg_fifo_data, '0);
      end
      apb_xfer(1'b0, reg_fifo_data, '0);
      check_value("empty fifo read", 0, rdata);
      apb_xfer(1'b0, reg_status, '0);
      check_value("drained status", 32'h0000_000C, rdata);

      if (uut.u_assertions.fail_cnt == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1, "protocol assertions failed during the run");
      end
   end

endmodule

`default_nettype wire

/* all.f */
hw/trace_pkg.sv
hw/trace_ctrl.sv
hw/trace_matcher.sv
hw/trigger_pulse.sv
hw/capture_fifo.sv
hw/trace_top.sv
tests/trace_assertions.sv
tests/trace_tb.sv

/* Bender.yml */
package:
  name: trace_sniffer

sources:
  - files:
      - hw/trace_pkg.sv
      - hw/trace_ctrl.sv
      - hw/trace_matcher.sv
      - hw/trigger_pulse.sv
      - hw/capture_fifo.sv
      - hw/trace_top.sv
  - target: test
    files:
      - tests/trace_assertions.sv
      - tests/trace_tb.sv
